/* hw/wr_resp_pkg.sv */
// Shared constants for the write-response model; PTR_W must stay log2 of OUTSTANDING_DEPTH
package wr_resp_pkg;

    // ----------------------------------------------------------------------
    // Table geometry
    // ----------------------------------------------------------------------
    localparam int unsigned OUTSTANDING_DEPTH = 8;
    localparam int unsigned PTR_W             = $clog2(OUTSTANDING_DEPTH);

    // ----------------------------------------------------------------------
    // AXI field widths and response codes
    // ----------------------------------------------------------------------
    localparam int unsigned ID_W   = 4;
    localparam int unsigned USER_W = 4;
    localparam int unsigned RESP_W = 2;

    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // This ID always answers with SLVERR
    localparam logic [ID_W-1:0] ERR_ID = 4'hF;

    // ----------------------------------------------------------------------
    // Backend latency model
    // ----------------------------------------------------------------------
    // Counter must be wide enough to reach DELAY_MAX minus any ID
    localparam int unsigned            DELAY_CNT_W = 5;
    localparam logic [DELAY_CNT_W-1:0] DELAY_MAX   = 5'd31;

endpackage

/* hw/rr_index_arb.sv */
// Round-robin index picker; with no request set the index is the start position
`timescale 1ns/10ps
module rr_index_arb (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0]   req_bits,
    input  logic                                        advance,
    output logic [wr_resp_pkg::PTR_W-1:0]               index
);

    logic [wr_resp_pkg::PTR_W-1:0] start_q;

    // First set request at or after the start position, wrapping around
    always_comb begin
        logic [wr_resp_pkg::PTR_W-1:0] cand;
        logic                          found;
        index = start_q;
        found = 1'b0;
        for (int k = 0; k < wr_resp_pkg::OUTSTANDING_DEPTH; k++) begin
            cand = start_q + k[wr_resp_pkg::PTR_W-1:0];
            if (!found && req_bits[cand]) begin
                index = cand;
                found = 1'b1;
            end
        end
    end

    // The start parks on the current pick so a waiting request keeps
    // its slot; it moves past the pick once the pick is consumed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= '0;
        end else if (advance) begin
            start_q <= index + 1'b1;
        end else begin
            start_q <= index;
        end
    end

endmodule

/* hw/w_beat_order.sv */
// W burst to entry mapping in AW order; a W burst must not lead its own AW by a cycle
`timescale 1ns/10ps
module w_beat_order (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          alloc,
    input  logic [wr_resp_pkg::PTR_W-1:0] alloc_ptr,
    input  logic                          beat_last,
    output logic [wr_resp_pkg::PTR_W-1:0] data_ptr
);

    logic [wr_resp_pkg::PTR_W-1:0] ptr_mem [wr_resp_pkg::OUTSTANDING_DEPTH];
    // One extra bit tells full from empty
    logic [wr_resp_pkg::PTR_W:0]   wr_cnt;
    logic [wr_resp_pkg::PTR_W:0]   rd_cnt;
    logic                          empty;
    logic                          pop;

    assign empty = (wr_cnt == rd_cnt);

    // An AW arriving together with the last beat of its burst bypasses the FIFO
    assign pop      = beat_last & (~empty | alloc);
    assign data_ptr = empty ? alloc_ptr : ptr_mem[rd_cnt[wr_resp_pkg::PTR_W-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            if (alloc) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (pop) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // Pointer storage
    always_ff @(posedge clk) begin
        if (alloc) begin
            ptr_mem[wr_cnt[wr_resp_pkg::PTR_W-1:0]] <= alloc_ptr;
        end
    end

endmodule

/* hw/b_id_order.sv */
// Per-ID age tracking; retire must only name an entry that is oldest for its ID
`timescale 1ns/10ps
module b_id_order (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      alloc,
    input  logic [wr_resp_pkg::PTR_W-1:0]             alloc_ptr,
    input  logic [wr_resp_pkg::ID_W-1:0]              awid,
    input  logic                                      retire,
    input  logic [wr_resp_pkg::PTR_W-1:0]             retire_ptr,
    output logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] oldest_bits
);

    logic [wr_resp_pkg::ID_W-1:0]              id_q    [wr_resp_pkg::OUTSTANDING_DEPTH];
    logic [wr_resp_pkg::PTR_W-1:0]             older_q [wr_resp_pkg::OUTSTANDING_DEPTH];
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] vld_q;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] alloc_sel;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] retire_sel;
    logic [wr_resp_pkg::PTR_W-1:0]             older_init;
    logic [wr_resp_pkg::ID_W-1:0]              retire_id;

    assign alloc_sel  = {{(wr_resp_pkg::OUTSTANDING_DEPTH-1){1'b0}}, alloc} << alloc_ptr;
    assign retire_sel = {{(wr_resp_pkg::OUTSTANDING_DEPTH-1){1'b0}}, retire} << retire_ptr;
    assign retire_id  = id_q[retire_ptr];

    // Live entries with the same ID, not counting one that leaves this cycle
    always_comb begin
        older_init = '0;
        for (int j = 0; j < wr_resp_pkg::OUTSTANDING_DEPTH; j++) begin
            if (vld_q[j] && !retire_sel[j] && (id_q[j] == awid)) begin
                older_init = older_init + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Age counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
            for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
                if (alloc_sel[i]) begin
                    vld_q[i]   <= 1'b1;
                    older_q[i] <= older_init;
                end else if (retire_sel[i]) begin
                    vld_q[i] <= 1'b0;
                end else if (retire && vld_q[i] && (id_q[i] == retire_id)
                             && (older_q[i] != '0)) begin
                    older_q[i] <= older_q[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                id_q[i] <= awid;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
            oldest_bits[i] = vld_q[i] && (older_q[i] == '0);
        end
    end

endmodule

/* hw/resp_delay_timer.sv */
// Backend latency model; an entry's response is ready DELAY_MAX + 1 - ID cycles after its last beat
`timescale 1ns/10ps
module resp_delay_timer (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      burst_done,
    input  logic [wr_resp_pkg::PTR_W-1:0]             data_ptr,
    input  logic [wr_resp_pkg::ID_W-1:0]              entry_ids [wr_resp_pkg::OUTSTANDING_DEPTH],
    output logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] resp_ready_bits
);

    logic [wr_resp_pkg::DELAY_CNT_W-1:0]       cnt_q [wr_resp_pkg::OUTSTANDING_DEPTH];
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] done_sel;

    assign done_sel = {{(wr_resp_pkg::OUTSTANDING_DEPTH-1){1'b0}}, burst_done} << data_ptr;

    // Zero means idle; a finished burst starts its entry at 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
                if (done_sel[i]) begin
                    cnt_q[i] <= {{(wr_resp_pkg::DELAY_CNT_W-1){1'b0}}, 1'b1};
                end else if (cnt_q[i] == wr_resp_pkg::DELAY_MAX) begin
                    cnt_q[i] <= '0;
                end else if (cnt_q[i] != '0) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // Higher IDs come back sooner
    always_comb begin
        logic [wr_resp_pkg::DELAY_CNT_W-1:0] id_ext;
        for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
            id_ext                         = '0;
            id_ext[wr_resp_pkg::ID_W-1:0]  = entry_ids[i];
            resp_ready_bits[i] = (cnt_q[i] != '0)
                                 && (cnt_q[i] == wr_resp_pkg::DELAY_MAX - id_ext);
        end
    end

endmodule

/* hw/wr_entry_table.sv */
// Outstanding write table; an entry is reusable two cycles after its B handshake
`timescale 1ns/10ps
module wr_entry_table (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      awvalid,
    output logic                                      awready,
    input  logic [wr_resp_pkg::ID_W-1:0]              awid,
    input  logic [wr_resp_pkg::USER_W-1:0]            awuser,
    input  logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] resp_ready_bits,
    input  logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] oldest_bits,
    output logic                                      bvalid,
    input  logic                                      bready,
    output logic [wr_resp_pkg::ID_W-1:0]              bid,
    output logic [wr_resp_pkg::RESP_W-1:0]            bresp,
    output logic [wr_resp_pkg::USER_W-1:0]            buser,
    output logic                                      alloc,
    output logic [wr_resp_pkg::PTR_W-1:0]             alloc_ptr,
    output logic                                      retire,
    output logic [wr_resp_pkg::PTR_W-1:0]             retire_ptr,
    output logic [wr_resp_pkg::ID_W-1:0]              entry_ids [wr_resp_pkg::OUTSTANDING_DEPTH]
);

    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] valid_q;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] result_q;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] comp_q;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] clear_q;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] alloc_sel;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] retire_sel;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] clr_sel;
    logic [wr_resp_pkg::ID_W-1:0]              id_q   [wr_resp_pkg::OUTSTANDING_DEPTH];
    logic [wr_resp_pkg::USER_W-1:0]            user_q [wr_resp_pkg::OUTSTANDING_DEPTH];
    logic [wr_resp_pkg::RESP_W-1:0]            resp_q [wr_resp_pkg::OUTSTANDING_DEPTH];
    logic [wr_resp_pkg::PTR_W-1:0]             clr_ptr;
    logic                                      clr_en;

    // ----------------------------------------------------------------------
    // Pickers
    // ----------------------------------------------------------------------
    rr_index_arb i_free_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_bits (~valid_q),
        .advance  (alloc),
        .index    (alloc_ptr)
    );

    // Only the oldest entry of each ID may answer
    rr_index_arb i_resp_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_bits (result_q & oldest_bits),
        .advance  (retire),
        .index    (retire_ptr)
    );

    rr_index_arb i_clear_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_bits (clear_q),
        .advance  (clr_en),
        .index    (clr_ptr)
    );

    // Nothing is accepted while in reset
    assign awready = rst_n & ~&valid_q;
    assign alloc   = awvalid & awready;
    assign bvalid  = result_q[retire_ptr] & oldest_bits[retire_ptr];
    assign retire  = bvalid & bready;
    assign clr_en  = clear_q[clr_ptr] & valid_q[clr_ptr]
                     & ~result_q[clr_ptr] & ~comp_q[clr_ptr];

    assign alloc_sel  = {{(wr_resp_pkg::OUTSTANDING_DEPTH-1){1'b0}}, alloc} << alloc_ptr;
    assign retire_sel = {{(wr_resp_pkg::OUTSTANDING_DEPTH-1){1'b0}}, retire} << retire_ptr;
    assign clr_sel    = {{(wr_resp_pkg::OUTSTANDING_DEPTH-1){1'b0}}, clr_en} << clr_ptr;

    // ----------------------------------------------------------------------
    // Entry flags
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            result_q <= '0;
            comp_q   <= '0;
            clear_q  <= '0;
        end else begin
            for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
                if (alloc_sel[i]) begin
                    valid_q[i] <= 1'b1;
                end else if (clr_sel[i]) begin
                    valid_q[i] <= 1'b0;
                end
                // Result pending from the ready pulse until the B handshake
                if (alloc_sel[i]) begin
                    result_q[i] <= 1'b0;
                end else if (resp_ready_bits[i] && valid_q[i]) begin
                    result_q[i] <= 1'b1;
                end else if (retire_sel[i]) begin
                    result_q[i] <= 1'b0;
                end
                if (alloc_sel[i]) begin
                    comp_q[i] <= 1'b1;
                end else if (retire_sel[i]) begin
                    comp_q[i] <= 1'b0;
                end
                clear_q[i] <= valid_q[i] & ~result_q[i] & ~comp_q[i];
            end
        end
    end

    // Stored AW fields and the response code
    always_ff @(posedge clk) begin
        for (int i = 0; i < wr_resp_pkg::OUTSTANDING_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                id_q[i]   <= awid;
                user_q[i] <= awuser;
            end
            if (resp_ready_bits[i]) begin
                resp_q[i] <= (id_q[i] == wr_resp_pkg::ERR_ID) ? wr_resp_pkg::RESP_SLVERR
                                                              : wr_resp_pkg::RESP_OKAY;
            end
        end
    end

    assign entry_ids = id_q;
    assign bid       = id_q[retire_ptr];
    assign bresp     = resp_q[retire_ptr];
    assign buser     = user_q[retire_ptr];

endmodule

/* hw/axi_wr_resp_slave.sv */
// AXI write-side slave model; W data is accepted and discarded, only B carries results
`timescale 1ns/10ps
module axi_wr_resp_slave (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [wr_resp_pkg::ID_W-1:0]       awid,
    input  logic [wr_resp_pkg::USER_W-1:0]     awuser,
    input  logic                               wvalid,
    output logic                               wready,
    input  logic                               wlast,
    output logic                               bvalid,
    input  logic                               bready,
    output logic [wr_resp_pkg::ID_W-1:0]       bid,
    output logic [wr_resp_pkg::RESP_W-1:0]     bresp,
    output logic [wr_resp_pkg::USER_W-1:0]     buser
);

    logic                                      alloc;
    logic [wr_resp_pkg::PTR_W-1:0]             alloc_ptr;
    logic                                      retire;
    logic [wr_resp_pkg::PTR_W-1:0]             retire_ptr;
    logic [wr_resp_pkg::PTR_W-1:0]             data_ptr;
    logic                                      beat_last;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] resp_ready_bits;
    logic [wr_resp_pkg::OUTSTANDING_DEPTH-1:0] oldest_bits;
    logic [wr_resp_pkg::ID_W-1:0]              entry_ids [wr_resp_pkg::OUTSTANDING_DEPTH];

    // W never stalls
    assign wready    = 1'b1;
    assign beat_last = wvalid & wlast;

    wr_entry_table i_wr_entry_table (
        .clk             (clk),
        .rst_n           (rst_n),
        .awvalid         (awvalid),
        .awready         (awready),
        .awid            (awid),
        .awuser          (awuser),
        .resp_ready_bits (resp_ready_bits),
        .oldest_bits     (oldest_bits),
        .bvalid          (bvalid),
        .bready          (bready),
        .bid             (bid),
        .bresp           (bresp),
        .buser           (buser),
        .alloc           (alloc),
        .alloc_ptr       (alloc_ptr),
        .retire          (retire),
        .retire_ptr      (retire_ptr),
        .entry_ids       (entry_ids)
    );

    w_beat_order i_w_beat_order (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc     (alloc),
        .alloc_ptr (alloc_ptr),
        .beat_last (beat_last),
        .data_ptr  (data_ptr)
    );

    b_id_order i_b_id_order (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (alloc),
        .alloc_ptr   (alloc_ptr),
        .awid        (awid),
        .retire      (retire),
        .retire_ptr  (retire_ptr),
        .oldest_bits (oldest_bits)
    );

    resp_delay_timer i_resp_delay_timer (
        .clk             (clk),
        .rst_n           (rst_n),
        .burst_done      (beat_last),
        .data_ptr        (data_ptr),
        .entry_ids       (entry_ids),
        .resp_ready_bits (resp_ready_bits)
    );

endmodule

/* tests/axi_wr_resp_asserts.sv */
// Bound into the slave top level; counts failures so the testbench can include them
`timescale 1ns/10ps
module axi_wr_resp_asserts (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           awready,
    input logic                           bvalid,
    input logic                           bready,
    input logic [wr_resp_pkg::ID_W-1:0]   bid,
    input logic [wr_resp_pkg::RESP_W-1:0] bresp,
    input logic [wr_resp_pkg::USER_W-1:0] buser
);

    int unsigned hold_fails  = 0;
    int unsigned reset_fails = 0;

    // A stalled B keeps its payload until bready
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp) && $stable(buser))
    else begin
        $error("B payload changed while bvalid waited for bready");
        hold_fails++;
    end

    // Nothing offered on AW or B while in reset
    reset_levels: assert property (@(posedge clk) !rst_n |-> !awready && !bvalid)
    else begin
        $error("awready or bvalid high during reset");
        reset_fails++;
    end

endmodule

bind axi_wr_resp_slave axi_wr_resp_asserts i_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .awready (awready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bid     (bid),
    .bresp   (bresp),
    .buser   (buser)
);

/* tests/tb_axi_wr_resp_slave.sv */
// Must run from the project root to find tests/wr_resp_cases.txt; B order is checked per ID
`timescale 1ns/10ps
module tb_axi_wr_resp_slave;

    localparam int MAX_WRITES = 32;

    logic                           clk;
    logic                           rst_n;
    logic                           awvalid;
    logic                           awready;
    logic [wr_resp_pkg::ID_W-1:0]   awid;
    logic [wr_resp_pkg::USER_W-1:0] awuser;
    logic                           wvalid;
    logic                           wready;
    logic                           wlast;
    logic                           bvalid;
    logic                           bready;
    logic [wr_resp_pkg::ID_W-1:0]   bid;
    logic [wr_resp_pkg::RESP_W-1:0] bresp;
    logic [wr_resp_pkg::USER_W-1:0] buser;

    // Five words per write for test, ID, user, beats and B stall mode
    logic [7:0] case_mem [0:5*MAX_WRITES-1];
    // Expected B per write as {id, user, resp} with the oldest first
    logic [9:0] ref_q [$];
    int         seed = 32'h767b;
    int         stall_mode;
    logic       hold_b;
    string      test_name;
    int         errors;
    int         test_errors;
    int         first_bid;
    int         watchdog_cycles;

    axi_wr_resp_slave i_axi_wr_resp_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awid    (awid),
        .awuser  (awuser),
        .wvalid  (wvalid),
        .wready  (wready),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid),
        .bresp   (bresp),
        .buser   (buser)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // B side bready driver and response checker
    // ----------------------------------------------------------------------
    initial begin
        int   rnd;
        logic next_bready;
        bready = 1'b0;
        forever begin
            @(posedge clk);
            next_bready = 1'b1;
            if (stall_mode == 1 && hold_b) begin
                next_bready = 1'b0;
            end else if (stall_mode == 2) begin
                rnd = $random(seed);
                next_bready = rnd[0];
            end
            #10;
            bready = next_bready;
        end
    end

    // Sampled mid-cycle where the handshake of the next edge is settled
    initial begin
        int match;
        forever begin
            @(negedge clk);
            if (rst_n && bvalid && bready) begin
                match = -1;
                for (int k = 0; k < ref_q.size(); k++) begin
                    if (match < 0 && ref_q[k][9:6] == bid) begin
                        match = k;
                    end
                end
                if (match < 0) begin
                    $display("ERROR %s: B response with ID %0h has no outstanding write",
                             test_name, bid);
                    errors++;
                    test_errors++;
                end else begin
                    check_value("bresp", int'(ref_q[match][1:0]), int'(bresp));
                    check_value("buser", int'(ref_q[match][5:2]), int'(buser));
                    ref_q.delete(match);
                end
                if (first_bid < 0) begin
                    first_bid = int'(bid);
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // AW and W driver
    // ----------------------------------------------------------------------
    task automatic send_write(input logic [wr_resp_pkg::ID_W-1:0] id,
                              input logic [wr_resp_pkg::USER_W-1:0] user, input int beats);
        logic [wr_resp_pkg::RESP_W-1:0] resp_exp;
        resp_exp = (id == wr_resp_pkg::ERR_ID) ? wr_resp_pkg::RESP_SLVERR
                                               : wr_resp_pkg::RESP_OKAY;
        awvalid = 1'b1;
        awid    = id;
        awuser  = user;
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        awvalid = 1'b0;
        ref_q.push_back({id, user, resp_exp});
        for (int b = 0; b < beats; b++) begin
            wvalid = 1'b1;
            wlast  = (b == beats - 1);
            @(negedge clk);
            check_value("wready", 1, int'(wready));
            @(posedge clk);
            #10;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic run_test(input int first, input int last);
        int n;
        int wait_cnt;
        int max_id;
        n           = last - first;
        test_name   = $sformatf("test %0d", case_mem[5*first]);
        test_errors = 0;
        first_bid   = -1;
        max_id      = 0;
        stall_mode  = int'(case_mem[5*first+4]);
        hold_b      = (stall_mode == 1);
        for (int i = first; i < last; i++) begin
            send_write(case_mem[5*i+1][3:0], case_mem[5*i+2][3:0], int'(case_mem[5*i+3]));
            if (int'(case_mem[5*i+1]) > max_id) begin
                max_id = int'(case_mem[5*i+1]);
            end
        end
        // All entries held by stalled B responses
        if (stall_mode == 1 && n == wr_resp_pkg::OUTSTANDING_DEPTH) begin
            check_value("awready with table full", 0, int'(awready));
        end
        hold_b = 1'b0;
        while (ref_q.size() != 0) begin
            @(posedge clk);
        end
        // With two IDs finishing close together the higher ID answers first
        if (n == 2 && case_mem[5*first+1] != case_mem[5*first+6]) begin
            check_value("first bid", max_id, first_bid);
        end
        wait_cnt = 0;
        @(negedge clk);
        while (!awready && wait_cnt < 16) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!awready) begin
            $display("ERROR %s: awready stayed low after all B responses", test_name);
            errors++;
            test_errors++;
        end
        repeat (8) @(posedge clk);
        #10;
        $display("%s: %0d writes, %0d errors", test_name, n, test_errors);
    endtask

    initial begin
        int n_writes;
        int n_tests;
        int idx;
        int last;
        rst_n           = 1'b1;
        awvalid         = 1'b0;
        awid            = '0;
        awuser          = '0;
        wvalid          = 1'b0;
        wlast           = 1'b0;
        stall_mode      = 0;
        hold_b          = 1'b0;
        errors          = 0;
        test_errors     = 0;
        first_bid       = -1;
        watchdog_cycles = 0;
        test_name       = "setup";
        for (int i = 0; i < 5*MAX_WRITES; i++) begin
            case_mem[i] = '0;
        end
        $readmemh("tests/wr_resp_cases.txt", case_mem);
        n_writes = 0;
        while (n_writes < MAX_WRITES && case_mem[5*n_writes] != 0) begin
            n_writes++;
        end
        if (n_writes == 0) begin
            $display("No writes were read from tests/wr_resp_cases.txt");
            errors++;
        end
        watchdog_cycles = n_writes * (8 + 40) + 500;
        #10 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #10 rst_n = 1'b1;
        n_tests = 0;
        idx     = 0;
        while (idx < n_writes) begin
            last = idx;
            while (last < n_writes && case_mem[5*last] == case_mem[5*idx]) begin
                last++;
            end
            run_test(idx, last);
            n_tests++;
            idx = last;
        end
        errors += int'(i_axi_wr_resp_slave.i_asserts.hold_fails);
        errors += int'(i_axi_wr_resp_slave.i_asserts.reset_fails);
        $display("%0d tests, %0d writes, %0d errors", n_tests, n_writes, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* tests/wr_resp_cases.txt */
// One write per line, hex: test number, AWID, AWUSER, W beats, B stall mode
// B stall mode: 0 bready high, 1 bready low until all AWs are sent, 2 random bready
1 3 5 1 0
2 f a 2 0
3 2 1 1 0
3 9 2 1 0
4 6 1 2 0
4 6 2 3 0
4 6 3 1 0
5 0 0 1 1
5 5 1 2 1
5 5 2 1 1
5 a 3 4 1
5 f 4 1 1
5 1 5 3 1
5 5 6 1 1
5 c 7 2 1
6 2 8 1 2
6 7 9 3 2
6 2 a 2 2
6 f b 1 2
6 b c 4 2
6 7 d 1 2
6 0 e 2 2
6 e f 1 2
6 2 0 8 2
6 b 1 1 2
6 f 2 2 2
6 4 3 1 2

/* all.f */
hw/wr_resp_pkg.sv
hw/rr_index_arb.sv
hw/w_beat_order.sv
hw/b_id_order.sv
hw/resp_delay_timer.sv
hw/wr_entry_table.sv
hw/axi_wr_resp_slave.sv
tests/axi_wr_resp_asserts.sv
tests/tb_axi_wr_resp_slave.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
    --top-module tb_axi_wr_resp_slave -f all.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "TEST RESULT: PASS" sim.log
